/* fas_top.f */
+incdir+include
src/fas_dsp_pkg.sv
src/fas_frame_pkg.sv
src/fir_filter.sv
src/frame_collector.sv
src/fft_stage.sv
src/fft16_core.sv
src/peak_detector.sv
src/fas_top.sv
verif/fas_tb.sv

/* Makefile */
# Verilator build for the frequency analyser testbench

TOP      ?= fas_tb
FILELIST ?= fas_top.f
VFLAGS   ?= --assert --timing
BUILD    ?= obj_dir
PASS_MSG ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	verilator --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD) -o V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

/* include/fas_ref_model.svh */
//////////////////////////////////////////////////
// Bit-exact reference functions for the analyser testbench
// Include inside the testbench module body
//////////////////////////////////////////////////
`ifndef FAS_REF_MODEL_SVH
`define FAS_REF_MODEL_SVH

// FIR result from the taps held before the shift, hist[0] newest
function automatic fas_dsp_pkg::sample_t ref_fir(
  input fas_dsp_pkg::sample_t hist [fas_dsp_pkg::FIR_TAPS]
);
  longint acc;
  acc = 0;
  for (int i = 0; i < fas_dsp_pkg::FIR_TAPS; i++) begin
    acc += longint'(hist[i]) * longint'(fas_dsp_pkg::FIR_COEF[i]);
  end
  return {acc[63], acc[30:16]} + {15'd0, acc[63]};
endfunction

// DIF FFT with Q16 rescale per stage, bins returned in natural order
function automatic fas_frame_pkg::spectrum_t ref_fft(input fas_frame_pkg::frame_t f);
  fas_frame_pkg::stage_vec_t v;
  fas_frame_pkg::stage_vec_t n;
  fas_frame_pkg::cplx_t      d;
  fas_frame_pkg::spectrum_t  s;
  fas_dsp_pkg::twiddle_t     wr;
  fas_dsp_pkg::twiddle_t     wi;
  logic signed [58:0]        pr;
  logic signed [58:0]        pq;
  logic [3:0]                r;
  for (int i = 0; i < 16; i++) begin
    v[i].re = fas_frame_pkg::stage_word_t'($signed(f[i])) <<< 16;
    v[i].im = '0;
  end
  for (int span = 8; span >= 1; span /= 2) begin
    for (int g = 0; g < 16; g += 2 * span) begin
      for (int k = 0; k < span; k++) begin
        wr   = fas_dsp_pkg::TW_RE[k * (8 / span)];
        wi   = fas_dsp_pkg::TW_IM[k * (8 / span)];
        d.re = v[g+k].re - v[g+k+span].re;
        d.im = v[g+k].im - v[g+k+span].im;
        n[g+k].re = v[g+k].re + v[g+k+span].re;
        n[g+k].im = v[g+k].im + v[g+k+span].im;
        pr = 59'(d.re) * 59'(wr) - 59'(d.im) * 59'(wi);
        pq = 59'(d.re) * 59'(wi) + 59'(d.im) * 59'(wr);
        n[g+k+span].re = pr[16 +: 40];
        n[g+k+span].im = pq[16 +: 40];
      end
    end
    v = n;
  end
  for (int i = 0; i < 16; i++) begin
    r = 4'(i);
    s[{r[0], r[1], r[2], r[3]}].re = {v[i].re[39], v[i].re[30:16]};
    s[{r[0], r[1], r[2], r[3]}].im = {v[i].im[39], v[i].im[30:16]};
  end
  return s;
endfunction

// Pairwise tree search, ties go to the higher bin
function automatic fas_frame_pkg::bin_idx_t ref_peak(input fas_frame_pkg::spectrum_t s);
  longint pw  [16];
  int     idx [16];
  for (int i = 0; i < 16; i++) begin
    pw[i]  = longint'(s[i].re) * longint'(s[i].re) + longint'(s[i].im) * longint'(s[i].im);
    idx[i] = i;
  end
  for (int m = 8; m >= 1; m /= 2) begin
    for (int i = 0; i < m; i++) begin
      if (pw[2*i] > pw[2*i+1]) begin
        pw[i]  = pw[2*i];
        idx[i] = idx[2*i];
      end else begin
        pw[i]  = pw[2*i+1];
        idx[i] = idx[2*i+1];
      end
    end
  end
  return 4'(idx[0]);
endfunction

`endif

/* verif/fas_tb.sv */
//////////////////////////////////////////////////
// Testbench for the frequency analyser top level
// Random bursts checked every cycle against a bit-exact model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fas_tb;
  import fas_dsp_pkg::*;
  import fas_frame_pkg::*;

  `include "fas_ref_model.svh"

  localparam int  N_BURSTS    = 6;
  localparam int  MIN_BURST   = 40;
  localparam int  MIN_TONE    = 80;                  // Long enough for two frames
  localparam int  MAX_BURST   = 200;
  localparam int  MAX_IDLE    = 5;
  localparam int  TONE_BIN    = 1;
  localparam int  TONE_AMP    = 2000;                // Tone bins stay inside 16 bits
  localparam real PI          = 3.14159265358979;
  localparam int  FFT_LAT     = 6;                   // Last frame sample to fft_valid
  localparam int  PEAK_LAT    = 11;                  // Last frame sample to done
  localparam int  TIMEOUT_CYC = 2 * N_BURSTS * (MAX_BURST + MAX_IDLE) + 540;

  logic      clk;
  logic      rst;
  logic      data_valid;
  sample_t   data;
  logic      fir_valid;
  sample_t   fir_d;
  logic      fft_valid;
  spectrum_t spectrum;
  logic      done;
  bin_idx_t  freq;

  // Model state
  sample_t   model_taps [FIR_TAPS];                  // Index 0 newest
  sample_t   frame_q [$];
  int        fft_due [$];
  spectrum_t spec_q [$];
  int        peak_due [$];
  bin_idx_t  peak_q [$];
  int        tone_q [$];                             // Tone bin of the frame, or -1
  int        fill;
  int        cyc;
  int        burst_tone;
  bin_idx_t  exp_freq;

  int fir_errs     = 0;
  int fft_errs     = 0;
  int peak_errs    = 0;
  int misc_errs    = 0;
  int run_cycles   = 0;

  fas_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .fft_valid  (fft_valid),
    .spectrum   (spectrum),
    .done       (done),
    .freq       (freq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Per-cycle model and output checks
  //////////////////////////////////////////////////
  task automatic check_outputs();
    sample_t   exp_d;
    logic      exp_v;
    logic      due;
    frame_t    f;
    spectrum_t s;
    exp_d = '0;
    cyc++;
    if (data_valid) begin
      exp_d = ref_fir(model_taps);                   // Taps before the shift
      for (int i = FIR_TAPS - 1; i > 0; i--) begin
        model_taps[i] = model_taps[i-1];
      end
      model_taps[0] = data;
      if (fill < FIR_FILL) begin
        fill++;
      end
    end else begin
      fill = 0;
    end
    exp_v = (fill == FIR_FILL);
    assert (fir_valid == exp_v) else begin
      $display("ERR fir_fill: expected %0b actual %0b at cycle %0d", exp_v, fir_valid, cyc);
      fir_errs++;
    end
    if (exp_v) begin
      assert (fir_d == exp_d) else begin
        $display("ERR fir_value: expected %0d actual %0d at cycle %0d", exp_d, fir_d, cyc);
        fir_errs++;
      end
      frame_q.push_back(exp_d);                      // Collected at the next edge
    end else begin
      frame_q.delete();                              // Partial frame dropped
    end
    if (frame_q.size() == FRAME_LEN) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        f[i] = frame_q[i];
      end
      s = ref_fft(f);
      fft_due.push_back(cyc + FFT_LAT);
      spec_q.push_back(s);
      peak_due.push_back(cyc + PEAK_LAT);
      peak_q.push_back(ref_peak(s));
      tone_q.push_back(burst_tone);
      frame_q.delete();
    end

    due = 1'b0;
    if (fft_due.size() > 0) begin
      due = (fft_due[0] == cyc);
    end
    assert (fft_valid == due) else begin
      $display("ERR fft_valid: expected %0b actual %0b at cycle %0d", due, fft_valid, cyc);
      fft_errs++;
    end
    if (due) begin
      assert (spectrum == spec_q[0]) else begin
        $display("ERR spectrum: expected %h actual %h", spec_q[0], spectrum);
        fft_errs++;
      end
      void'(fft_due.pop_front());
      void'(spec_q.pop_front());
    end

    due = 1'b0;
    if (peak_due.size() > 0) begin
      due = (peak_due[0] == cyc);
    end
    assert (done == due) else begin
      $display("ERR done: expected %0b actual %0b at cycle %0d", due, done, cyc);
      peak_errs++;
    end
    if (due) begin
      exp_freq = peak_q[0];
      if (tone_q[0] >= 0) begin                      // Real tone shows at k or 16-k
        assert (freq == 4'(tone_q[0]) || freq == 4'(FRAME_LEN - tone_q[0])) else begin
          $display("ERR tone_peak: expected %0d actual %0d", tone_q[0], freq);
          peak_errs++;
        end
      end
      void'(peak_due.pop_front());
      void'(peak_q.pop_front());
      void'(tone_q.pop_front());
    end
    assert (freq == exp_freq) else begin
      $display("ERR peak_bin: expected %0d actual %0d at cycle %0d", exp_freq, freq, cyc);
      peak_errs++;
    end
  endtask

  task automatic apply_cycle(input logic v, input sample_t d);
    @(negedge clk);
    check_outputs();
    data_valid = v;
    data       = d;
  endtask

  // Kind 0 random, 1 full scale, 2 pure tone
  task automatic drive_burst(input int kind);
    int      len;
    sample_t d;
    len = (kind == 2) ? int'($urandom_range(MIN_TONE, MAX_BURST))
                      : int'($urandom_range(MIN_BURST, MAX_BURST));
    burst_tone = (kind == 2) ? TONE_BIN : -1;
    for (int n = 0; n < len; n++) begin
      case (kind)
        0:       d = sample_t'($urandom);
        1:       d = ($urandom_range(0, 1) == 1) ? 16'sh7FFF : 16'sh8000;
        default: d = sample_t'($rtoi(TONE_AMP * $cos(2.0 * PI * n * TONE_BIN / FRAME_LEN)));
      endcase
      apply_cycle(1'b1, d);
    end
  endtask

  task automatic check_reset_state();
    assert (!fir_valid && !fft_valid && !done && freq == '0 && spectrum == '0) else begin
      $display("ERR reset_state: expected 0 actual fir_valid=%0b fft_valid=%0b done=%0b freq=%0d",
               fir_valid, fft_valid, done, freq);
      misc_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    fill       = 0;
    cyc        = 0;
    burst_tone = -1;
    exp_freq   = '0;
    for (int i = 0; i < FIR_TAPS; i++) begin
      model_taps[i] = '0;
    end
    void'($urandom(32'ha4c7));
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    for (int b = 0; b < N_BURSTS; b++) begin
      drive_burst(b % 3);
      repeat ($urandom_range(1, MAX_IDLE)) apply_cycle(1'b0, '0);
    end
    while (fft_due.size() > 0 || peak_due.size() > 0) begin
      apply_cycle(1'b0, '0);                         // Drain the pipeline
    end
    $display("Errors: fir=%0d fft=%0d peak=%0d other=%0d",
             fir_errs, fft_errs, peak_errs, misc_errs);
    if (fir_errs + fft_errs + peak_errs + misc_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    run_cycles++;
    if (run_cycles >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failed");
      $finish;
    end
  end

endmodule

/* src/fas_top.sv */
//////////////////////////////////////////////////
// Frequency analyser top, FIR to frame to FFT to peak
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fas_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     data_valid,
  input  fas_dsp_pkg::sample_t     data,
  output logic                     fir_valid,
  output fas_dsp_pkg::sample_t     fir_d,
  output logic                     fft_valid,
  output fas_frame_pkg::spectrum_t spectrum,
  output logic                     done,
  output fas_frame_pkg::bin_idx_t  freq
);
  import fas_frame_pkg::*;

  logic   frame_valid;
  frame_t frame;

  fir_filter u_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_collector u_collect (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  fft16_core u_fft (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .fft_valid   (fft_valid),
    .spectrum    (spectrum)
  );

  peak_detector u_peak (
    .clk       (clk),
    .rst       (rst),
    .fft_valid (fft_valid),
    .spectrum  (spectrum),
    .done      (done),
    .freq      (freq)
  );

endmodule

/* src/peak_detector.sv */
//////////////////////////////////////////////////
// Finds the spectrum bin with the largest power
// done pulses five cycles after fft_valid
//////////////////////////////////////////////////
`timescale 1ns/1ps

module peak_detector (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     fft_valid,
  input  fas_frame_pkg::spectrum_t spectrum,
  output logic                     done,
  output fas_frame_pkg::bin_idx_t  freq
);
  import fas_dsp_pkg::*;
  import fas_frame_pkg::*;

  localparam int LEVELS = $clog2(FRAME_LEN);
  localparam int HALF   = FRAME_LEN / 2;
  localparam int PWR_W  = $bits(power_t);

  typedef struct packed {
    power_t   pwr;
    bin_idx_t idx;
  } cand_t;

  logic [2:0] step;
  power_t     bin_pwr [FRAME_LEN];
  cand_t      cand    [FRAME_LEN];                  // Tree level results, packed low
  cand_t      win     [HALF];

  always_comb begin
    for (int i = 0; i < FRAME_LEN; i++) begin
      bin_pwr[i] = PWR_W'(spectrum[i].re) * PWR_W'(spectrum[i].re)
                 + PWR_W'(spectrum[i].im) * PWR_W'(spectrum[i].im);
    end
  end

  // Even entry wins only when strictly larger, so ties favour the higher bin
  always_comb begin
    for (int i = 0; i < HALF; i++) begin
      win[i] = (cand[2*i].pwr > cand[2*i+1].pwr) ? cand[2*i] : cand[2*i+1];
    end
  end

  //////////////////////////////////////////////////
  // Level sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      step <= '0;
    end else if (fft_valid) begin
      step <= 3'd1;
    end else if (step == '0 || done) begin
      step <= '0;
    end else begin
      step <= step + 3'd1;
    end
  end

  assign done = (step == 3'(LEVELS + 1));

  always_ff @(posedge clk) begin
    if (fft_valid) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        cand[i].pwr <= bin_pwr[i];
        cand[i].idx <= 4'(i);
      end
    end else if (step != '0 && step < 3'(LEVELS)) begin
      for (int i = 0; i < HALF; i++) begin
        cand[i] <= win[i];                          // Halves the field each level
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      freq <= '0;
    end else if (step == 3'(LEVELS)) begin
      freq <= win[0].idx;                           // Final level
    end
  end

endmodule

/* src/fft16_core.sv */
//////////////////////////////////////////////////
// 16-point DIF FFT, four stages then truncation to 16-bit bins
// fft_valid pulses five cycles after frame_valid
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fft16_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     frame_valid,
  input  fas_frame_pkg::frame_t    frame,
  output logic                     fft_valid,
  output fas_frame_pkg::spectrum_t spectrum
);
  import fas_dsp_pkg::*;
  import fas_frame_pkg::*;

  localparam int NUM_STAGES = $clog2(FRAME_LEN);
  localparam int STEP_W     = $clog2(FFT_STEPS + 1);

  logic [STEP_W-1:0]     step;
  logic [NUM_STAGES-1:0] stage_en;
  stage_vec_t            load_vec;
  stage_vec_t            stage_q [NUM_STAGES];

  function automatic bin_idx_t bit_rev(input bin_idx_t v);
    return {v[0], v[1], v[2], v[3]};
  endfunction

  // Sign bit followed by bits 30..16 of the Q16 word
  function automatic sample_t trunc_word(input stage_word_t w);
    return {w[$bits(stage_word_t)-1], w[Q_FRAC+SAMPLE_W-2:Q_FRAC]};
  endfunction

  //////////////////////////////////////////////////
  // Step sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      step <= '0;
    end else if (frame_valid) begin
      step <= STEP_W'(1);
    end else if (step == '0 || fft_valid) begin
      step <= '0;
    end else begin
      step <= step + STEP_W'(1);
    end
  end

  assign fft_valid = (step == STEP_W'(FFT_STEPS));

  always_comb begin
    stage_en[0] = frame_valid;                      // Step 0 loads and runs span 8
    for (int s = 1; s < NUM_STAGES; s++) begin
      stage_en[s] = (step == STEP_W'(s));
    end
  end

  // Real input widened to Q16, imaginary part zero
  always_comb begin
    for (int i = 0; i < FRAME_LEN; i++) begin
      load_vec[i].re = stage_word_t'($signed(frame[i])) <<< Q_FRAC;
      load_vec[i].im = '0;
    end
  end

  //////////////////////////////////////////////////
  // Butterfly stages, spans 8, 4, 2, 1
  //////////////////////////////////////////////////
  for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
    if (s == 0) begin : g_first
      fft_stage #(.SPAN(FRAME_LEN / 2)) u_stage (
        .clk       (clk),
        .rst       (rst),
        .en        (stage_en[s]),
        .stage_in  (load_vec),
        .stage_out (stage_q[s])
      );
    end else begin : g_next
      fft_stage #(.SPAN((FRAME_LEN / 2) >> s)) u_stage (
        .clk       (clk),
        .rst       (rst),
        .en        (stage_en[s]),
        .stage_in  (stage_q[s-1]),
        .stage_out (stage_q[s])
      );
    end
  end

  // Last stage leaves bins in bit-reversed order
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      spectrum <= '0;
    end else if (step == STEP_W'(FFT_STEPS - 1)) begin
      for (int i = 0; i < FRAME_LEN; i++) begin
        spectrum[i].re <= trunc_word(stage_q[NUM_STAGES-1][bit_rev(4'(i))].re);
        spectrum[i].im <= trunc_word(stage_q[NUM_STAGES-1][bit_rev(4'(i))].im);
      end
    end
  end

endmodule

/* src/fft_stage.sv */
//////////////////////////////////////////////////
// One radix-2 DIF butterfly stage, result held until next enable
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fft_stage #(
  parameter int SPAN = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en,
  input  fas_frame_pkg::stage_vec_t stage_in,
  output fas_frame_pkg::stage_vec_t stage_out
);
  import fas_dsp_pkg::*;
  import fas_frame_pkg::*;

  localparam int TW_STEP = FRAME_LEN / 2 / SPAN;    // Twiddle stride for this span
  localparam int WORD_W  = $bits(stage_word_t);
  localparam int PROD_W  = WORD_W + $bits(twiddle_t) + 1;

  stage_vec_t bfly;

  always_comb begin
    cplx_t                    a;
    cplx_t                    b;
    cplx_t                    d;
    twiddle_t                 wr;
    twiddle_t                 wi;
    logic signed [PROD_W-1:0] prod_re;
    logic signed [PROD_W-1:0] prod_im;

    for (int g = 0; g < FRAME_LEN; g += 2 * SPAN) begin
      for (int k = 0; k < SPAN; k++) begin
        a    = stage_in[g + k];
        b    = stage_in[g + k + SPAN];
        wr   = TW_RE[k * TW_STEP];
        wi   = TW_IM[k * TW_STEP];
        d.re = a.re - b.re;
        d.im = a.im - b.im;

        // Full products, rescaled to Q16 afterwards
        prod_re = PROD_W'(d.re) * PROD_W'(wr) - PROD_W'(d.im) * PROD_W'(wi);
        prod_im = PROD_W'(d.re) * PROD_W'(wi) + PROD_W'(d.im) * PROD_W'(wr);

        bfly[g + k].re        = a.re + b.re;
        bfly[g + k].im        = a.im + b.im;
        bfly[g + k + SPAN].re = prod_re[Q_FRAC +: WORD_W];  // Same as >>> Q_FRAC
        bfly[g + k + SPAN].im = prod_im[Q_FRAC +: WORD_W];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage_out <= '0;
    end else if (en) begin
      stage_out <= bfly;
    end
  end

endmodule

/* src/frame_collector.sv */
//////////////////////////////////////////////////
// Packs 16 consecutive filter outputs into one frame
//////////////////////////////////////////////////
`timescale 1ns/1ps

module frame_collector (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fir_valid,
  input  fas_dsp_pkg::sample_t  fir_d,
  output logic                  frame_valid,
  output fas_frame_pkg::frame_t frame
);
  import fas_dsp_pkg::*;
  import fas_frame_pkg::*;

  localparam int POS_W = $clog2(FRAME_LEN) + 1;     // Counts 0 to FRAME_LEN

  logic [POS_W-1:0] pos;

  // A full count means the frame register holds 16 new samples
  assign frame_valid = (pos == POS_W'(FRAME_LEN));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos <= '0;
    end else if (!fir_valid) begin
      pos <= '0;                                    // Partial frame is abandoned
    end else if (frame_valid) begin
      pos <= POS_W'(1);                             // Sample lands in slot 0 this cycle
    end else begin
      pos <= pos + POS_W'(1);
    end
  end

  // Slot index wraps to 0 when the count is full
  always_ff @(posedge clk) begin
    if (fir_valid) begin
      frame[pos[POS_W-2:0]] <= fir_d;
    end
  end

endmodule

/* src/fir_filter.sv */
//////////////////////////////////////////////////
// 32-tap low-pass FIR, one result per valid input
// fir_valid marks results once the delay line is full
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_filter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 data_valid,
  input  fas_dsp_pkg::sample_t data,
  output logic                 fir_valid,
  output fas_dsp_pkg::sample_t fir_d
);
  import fas_dsp_pkg::*;

  // Wide enough for 32 full products without overflow
  localparam int ACC_W = SAMPLE_W + $bits(coef_t) + $clog2(FIR_TAPS);

  sample_t                 taps [FIR_TAPS];         // Index 0 is the newest sample
  logic [5:0]              fill_cnt;
  logic signed [ACC_W-1:0] dot;
  logic signed [ACC_W-1:0] acc;
  logic                    neg;

  //////////////////////////////////////////////////
  // Multiply-accumulate over the taps before the shift
  //////////////////////////////////////////////////
  always_comb begin
    dot = '0;
    for (int i = 0; i < FIR_TAPS; i++) begin
      dot = dot + ACC_W'(taps[i]) * ACC_W'(FIR_COEF[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (data_valid) begin
      taps[0] <= data;
      for (int i = 1; i < FIR_TAPS; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt <= '0;
      acc      <= '0;
    end else if (data_valid) begin
      acc <= dot;
      if (fill_cnt != 6'(FIR_FILL)) begin
        fill_cnt <= fill_cnt + 6'd1;                // Saturates at the fill depth
      end
    end else begin
      fill_cnt <= '0;                               // Any gap restarts the run
      acc      <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Output scaling back to 16 bits
  //////////////////////////////////////////////////
  assign fir_valid = (fill_cnt == 6'(FIR_FILL));
  assign neg       = acc[ACC_W-1];

  // Sign plus bits 30..16, negative results move one step toward zero
  assign fir_d = {neg, acc[Q_FRAC+SAMPLE_W-2:Q_FRAC]}
               + {{(SAMPLE_W-1){1'b0}}, neg};

endmodule

/* src/fas_frame_pkg.sv */
//////////////////////////////////////////////////
// Types for samples, frames, stage vectors and spectra
//////////////////////////////////////////////////
package fas_frame_pkg;

  // Element 0 is the earliest sample of the frame
  typedef fas_dsp_pkg::sample_t [fas_dsp_pkg::FRAME_LEN-1:0] frame_t;

  typedef logic signed [39:0] stage_word_t;         // Q16 word between FFT stages

  typedef struct packed {
    stage_word_t re;
    stage_word_t im;
  } cplx_t;

  typedef cplx_t [fas_dsp_pkg::FRAME_LEN-1:0] stage_vec_t;

  typedef struct packed {
    logic signed [15:0] re;
    logic signed [15:0] im;
  } bin_t;

  typedef bin_t [fas_dsp_pkg::FRAME_LEN-1:0] spectrum_t;  // Indexed by bin number

  typedef logic [32:0] power_t;                     // re^2 + im^2 of one bin
  typedef logic [3:0]  bin_idx_t;

endpackage

/* src/fas_dsp_pkg.sv */
//////////////////////////////////////////////////
// Fixed arithmetic constants for the analyser
// FIR coefficient table and FFT twiddle tables in Q16
//////////////////////////////////////////////////
package fas_dsp_pkg;

  //////////////////////////////////////////////////
  // Sample and filter
  //////////////////////////////////////////////////
  localparam int SAMPLE_W = 16;
  localparam int FIR_TAPS = 32;
  localparam int FIR_FILL = 34;                     // Valid inputs before fir_valid rises
  localparam int Q_FRAC   = 16;                     // Fraction bits of every fixed-point word

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [19:0]         coef_t;       // 16 fraction bits

  // Symmetric low-pass response, entry 0 weights the newest tap
  localparam coef_t FIR_COEF [FIR_TAPS] = '{
    20'shFFF9E, 20'shFFF86, 20'shFFFA7, 20'sh0003B,
    20'sh0014B, 20'sh0024A, 20'sh00222, 20'shFFFE4,
    20'shFFBC5, 20'shFF7CA, 20'shFF74E, 20'shFFD74,
    20'sh00B1A, 20'sh01DAC, 20'sh02F9E, 20'sh03AA9,
    20'sh03AA9, 20'sh02F9E, 20'sh01DAC, 20'sh00B1A,
    20'shFFD74, 20'shFF74E, 20'shFF7CA, 20'shFFBC5,
    20'shFFFE4, 20'sh00222, 20'sh0024A, 20'sh0014B,
    20'sh0003B, 20'shFFFA7, 20'shFFF86, 20'shFFF9E
  };

  //////////////////////////////////////////////////
  // Frame and FFT
  //////////////////////////////////////////////////
  localparam int FRAME_LEN = 16;
  localparam int FFT_STEPS = 5;                     // Four stages plus truncation

  typedef logic signed [17:0] twiddle_t;

  // W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), k = 0..7
  localparam twiddle_t TW_RE [FRAME_LEN/2] = '{
    18'sd65536,  18'sd60547,  18'sd46340,  18'sd25079,
    18'sd0,      -18'sd25079, -18'sd46340, -18'sd60547
  };

  localparam twiddle_t TW_IM [FRAME_LEN/2] = '{
    18'sd0,      -18'sd25079, -18'sd46340, -18'sd60547,
    -18'sd65536, -18'sd60547, -18'sd46340, -18'sd25079
  };

endpackage
